// ==== build.f ====
hw/quarkPkg.sv
hw/decodeBus.sv
hw/instrDecode.sv
hw/regFile.sv
hw/quarkAlu.sv
hw/coreControl.sv
hw/quarkCore.sv
verification/quarkCore_chk.sv
verification/quarkCoreTb.sv

// ==== hw/coreControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreControl #(
   parameter quarkPkg::wordT resetAddr = 32'h0000_0000,
   parameter int             addrWidth = 24
) (
   input  wire                   clk,
   input  wire                   reset,
   decodeBus.ctrl                dec,
   input  quarkPkg::wordT        rs1,
   input  quarkPkg::wordT        rs2,
   input  quarkPkg::wordT        aluOut,
   input  quarkPkg::wordT        aluPlus,
   input  wire                   predicate,
   input  wire                   aluBusy,
   input  wire                   memRbusy,
   input  wire                   memWbusy,
   output logic                  load,
   output logic                  aluStart,
   output logic                  writeEn,
   output quarkPkg::wordT        writeData,
   output logic [addrWidth-1:0]  memAddr,
   output quarkPkg::wordT        memWdata,
   output logic [3:0]            memWmask,
   output logic                  memRstrb
);

   quarkPkg::coreStateT state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] storeAddr;
   logic isAlu;
   logic isShift;
   logic needToWait;
   logic jumpToImm;
   logic writesReg;

   assign isAlu   = dec.isAluImm | dec.isAluReg;
   assign isShift = (dec.funct3 == 3'b001) | (dec.funct3 == 3'b101);

   assign pcPlus4 = pc + addrWidth'(4);

   // One adder for JAL, AUIPC and branch targets
   assign pcPlusImm = pc + (dec.isJal   ? dec.jImm[addrWidth-1:0] :
                            dec.isAuipc ? dec.uImm[addrWidth-1:0] :
                                          dec.bImm[addrWidth-1:0]);

   // Word store address, low bits go out unchanged
   assign storeAddr = rs1[addrWidth-1:0] + dec.sImm[addrWidth-1:0];

   // PC on the bus while fetching, store address otherwise
   assign memAddr = ((state == quarkPkg::fetchInstr) || (state == quarkPkg::waitInstr)) ?
                    pc : storeAddr;
   assign memWdata = rs2;

   // Only full word stores, mask is all or nothing
   assign memWmask = {4{(state == quarkPkg::execute) & dec.isStore}};
   assign memRstrb = (state == quarkPkg::fetchInstr);

   // Instruction and operands arrive together
   assign load     = (state == quarkPkg::waitInstr) & !memRbusy;
   assign aluStart = (state == quarkPkg::execute) & isAlu;

   // Write-back source by opcode
   // Link value is the address after the jump
   always_comb begin
      if (dec.isLui) begin
         writeData = dec.uImm;
      end else if (isAlu) begin
         writeData = aluOut;
      end else if (dec.isAuipc) begin
         writeData = quarkPkg::wordT'(pcPlusImm);
      end else if (dec.isJal | dec.isJalr) begin
         writeData = quarkPkg::wordT'(pcPlus4);
      end else begin
         writeData = '0;
      end
   end

   // Unknown opcodes write nothing, same as branches and stores
   assign writesReg = dec.isLui | isAlu | dec.isAuipc | dec.isJal | dec.isJalr;
   // Shift result keeps landing until the count runs out
   assign writeEn = writesReg &
                    ((state == quarkPkg::execute) | (state == quarkPkg::waitAluMem));

   assign jumpToImm  = dec.isJal | (dec.isBranch & predicate);
   // Every store waits for the write side
   assign needToWait = dec.isStore | (isAlu & isShift);

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for memory to settle before the first fetch
         state <= quarkPkg::waitAluMem;
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         case (state)
            quarkPkg::fetchInstr: begin
               state <= quarkPkg::waitInstr;
            end
            quarkPkg::waitInstr: begin
               if (!memRbusy) begin
                  state <= quarkPkg::execute;
               end
            end
            quarkPkg::execute: begin
               if (dec.isJalr) begin
                  pc <= aluPlus[addrWidth-1:0];
               end else if (jumpToImm) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? quarkPkg::waitAluMem : quarkPkg::fetchInstr;
            end
            default: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= quarkPkg::fetchInstr;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/decodeBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded fields of the current instruction
interface decodeBus;

   // Raw instruction, bits 1 and 0 dropped
   logic [31:2] instr;
   quarkPkg::regIdT rdId;
   quarkPkg::funct3T funct3;

   // One-hot opcode flags
   logic isAluImm;
   logic isAluReg;
   logic isLui;
   logic isAuipc;
   logic isJal;
   logic isJalr;
   logic isBranch;
   logic isStore;

   // Sign-extended immediates
   quarkPkg::wordT iImm;
   quarkPkg::wordT sImm;
   quarkPkg::wordT bImm;
   quarkPkg::wordT jImm;
   quarkPkg::wordT uImm;

   modport source (
      output instr, rdId, funct3,
      output isAluImm, isAluReg, isLui, isAuipc, isJal, isJalr, isBranch, isStore,
      output iImm, sImm, bImm, jImm, uImm
   );

   // ALU needs operand select, SUB and SRA bits and the I immediate
   modport alu (input instr, funct3, isAluReg, isBranch, iImm);

   modport ctrl (
      input funct3,
      input isAluImm, isAluReg, isLui, isAuipc, isJal, isJalr, isBranch, isStore,
      input sImm, bImm, jImm, uImm
   );

endinterface

`default_nettype wire

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
   input  wire             clk,
   input  wire             load,
   input  quarkPkg::wordT  memRdata,
   decodeBus.source        dec
);

   // Instruction register, low two bits are always 11
   logic [31:2] instrQ;
   quarkPkg::opcodeT opcode;

   // Captured once per instruction when the fetch data arrives
   always_ff @(posedge clk) begin
      if (load) begin
         instrQ <= memRdata[31:2];
      end
   end

   assign opcode = instrQ[6:2];

   assign dec.instr  = instrQ;
   assign dec.rdId   = instrQ[11:7];
   assign dec.funct3 = instrQ[14:12];

   // One flag per opcode group
   // Unknown opcodes raise none of them
   assign dec.isAluImm = (opcode == quarkPkg::opAluImm);
   assign dec.isAluReg = (opcode == quarkPkg::opAluReg);
   assign dec.isLui    = (opcode == quarkPkg::opLui);
   assign dec.isAuipc  = (opcode == quarkPkg::opAuipc);
   assign dec.isJal    = (opcode == quarkPkg::opJal);
   assign dec.isJalr   = (opcode == quarkPkg::opJalr);
   assign dec.isBranch = (opcode == quarkPkg::opBranch);
   assign dec.isStore  = (opcode == quarkPkg::opStore);

   // U type, upper 20 bits
   assign dec.uImm = {instrQ[31:12], 12'b0};

   // I type, 12 bits sign extended
   assign dec.iImm = {{21{instrQ[31]}}, instrQ[30:20]};

   // S type, split across funct7 and rd fields
   assign dec.sImm = {{21{instrQ[31]}}, instrQ[30:25], instrQ[11:7]};

   // B type, even offsets only
   assign dec.bImm = {{20{instrQ[31]}}, instrQ[7], instrQ[30:25], instrQ[11:8], 1'b0};

   // J type, scrambled 20 bit offset
   assign dec.jImm = {{12{instrQ[31]}}, instrQ[19:12], instrQ[20], instrQ[30:21], 1'b0};

endmodule

`default_nettype wire

// ==== hw/quarkAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module quarkAlu (
   input  wire             clk,
   input  wire             start,
   decodeBus.alu           dec,
   input  quarkPkg::wordT  rs1,
   input  quarkPkg::wordT  rs2,
   output quarkPkg::wordT  aluOut,
   output quarkPkg::wordT  aluPlus,
   output logic            predicate,
   output logic            aluBusy
);

   quarkPkg::wordT aluIn2;
   logic [32:0] aluMinus;
   logic lt;
   logic ltu;
   logic eq;
   logic isShift;

   // Serial shifter state
   quarkPkg::wordT shiftReg;
   quarkPkg::shamtT shamt;

   // Register operand for ALUreg and branches, I immediate otherwise
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;

   // Shared adder, also gives the JALR target
   assign aluPlus = rs1 + aluIn2;

   // One 33 bit subtract for SUB and all compares
   // Top bit is the borrow, set when rs1 < aluIn2 unsigned
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu = aluMinus[32];
   // Signs differ so rs1 sign alone decides
   assign lt  = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq  = (aluMinus[31:0] == '0);

   // SLL is 001, SRL and SRA are 101
   assign isShift = (dec.funct3 == 3'b001) | (dec.funct3 == 3'b101);

   always_comb begin
      case (dec.funct3)
         // SUB needs instr[5] too, ADDI reuses bit 30 as immediate
         3'b000:  aluOut = (dec.instr[30] & dec.instr[5]) ? aluMinus[31:0] : aluPlus;
         3'b010:  aluOut = {31'b0, lt};
         3'b011:  aluOut = {31'b0, ltu};
         3'b100:  aluOut = rs1 ^ aluIn2;
         3'b110:  aluOut = rs1 | aluIn2;
         3'b111:  aluOut = rs1 & aluIn2;
         default: aluOut = shiftReg;
      endcase
   end

   // One bit per cycle after the start pulse
   always_ff @(posedge clk) begin
      if (start && isShift) begin
         shiftReg <= rs1;
         shamt    <= aluIn2[4:0];
      end else if (shamt != '0) begin
         shamt <= shamt - 5'd1;
         if (dec.funct3 == 3'b001) begin
            shiftReg <= shiftReg << 1;
         end else begin
            // instr[30] picks SRA sign fill over SRL zero fill
            shiftReg <= {dec.instr[30] & shiftReg[31], shiftReg[31:1]};
         end
      end
   end

   assign aluBusy = (shamt != '0);

   // Branch conditions, funct3 010 and 011 are not branches
   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/quarkCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module quarkCore #(
   parameter quarkPkg::wordT resetAddr = 32'h0000_0000,
   parameter int             addrWidth = 24
) (
   input  wire             clk,
   input  wire             reset,
   output quarkPkg::wordT  memAddr,
   output quarkPkg::wordT  memWdata,
   output logic [3:0]      memWmask,
   input  quarkPkg::wordT  memRdata,
   output logic            memRstrb,
   input  wire             memRbusy,
   input  wire             memWbusy
);

   // Fetch handshake and ALU start
   logic load;
   logic aluStart;

   // Register file write port
   logic writeEn;
   quarkPkg::wordT writeData;

   // Latched operands
   quarkPkg::wordT rs1;
   quarkPkg::wordT rs2;

   // ALU results
   quarkPkg::wordT aluOut;
   quarkPkg::wordT aluPlus;
   logic predicate;
   logic aluBusy;

   // Internal address, narrower than the bus
   logic [addrWidth-1:0] coreAddr;

   decodeBus dec ();

   instrDecode i_instrDecode (
      .clk      (clk),
      .load     (load),
      .memRdata (memRdata),
      .dec      (dec.source)
   );

   // Operands read from the fetch data, same edge as the instruction
   regFile i_regFile (
      .clk       (clk),
      .capture   (load),
      .memRdata  (memRdata),
      .writeEn   (writeEn),
      .rdId      (dec.rdId),
      .writeData (writeData),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   quarkAlu i_quarkAlu (
      .clk       (clk),
      .start     (aluStart),
      .dec       (dec.alu),
      .rs1       (rs1),
      .rs2       (rs2),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .predicate (predicate),
      .aluBusy   (aluBusy)
   );

   coreControl #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) i_coreControl (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec.ctrl),
      .rs1       (rs1),
      .rs2       (rs2),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .predicate (predicate),
      .aluBusy   (aluBusy),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .load      (load),
      .aluStart  (aluStart),
      .writeEn   (writeEn),
      .writeData (writeData),
      .memAddr   (coreAddr),
      .memWdata  (memWdata),
      .memWmask  (memWmask),
      .memRstrb  (memRstrb)
   );

   // Upper address bits are zero
   assign memAddr = quarkPkg::wordT'(coreAddr);

endmodule

`default_nettype wire

// ==== hw/quarkPkg.sv ====
`default_nettype none

package quarkPkg;

   // One data word
   typedef logic [31:0] wordT;

   // Register index, five bits for 32 registers
   typedef logic [4:0] regIdT;

   // Shift count
   typedef logic [4:0] shamtT;

   // Operation selector from instruction bits 14 to 12
   typedef logic [2:0] funct3T;

   // Major opcode from instruction bits 6 to 2
   // Bits 1 and 0 are always 11 in RV32I and are not kept
   typedef logic [4:0] opcodeT;

   // Opcodes of the kept instructions
   localparam opcodeT opLui    = 5'b01101;
   localparam opcodeT opAuipc  = 5'b00101;
   localparam opcodeT opJal    = 5'b11011;
   localparam opcodeT opJalr   = 5'b11001;
   localparam opcodeT opBranch = 5'b11000;
   localparam opcodeT opStore  = 5'b01000;
   localparam opcodeT opAluImm = 5'b00100;
   localparam opcodeT opAluReg = 5'b01100;

   // Control states, one instruction walks through them in order
   // waitAluMem also serves as the state after reset
   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitAluMem
   } coreStateT;

endpackage

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire              clk,
   input  wire              capture,
   input  quarkPkg::wordT   memRdata,
   input  wire              writeEn,
   input  quarkPkg::regIdT  rdId,
   input  quarkPkg::wordT   writeData,
   output quarkPkg::wordT   rs1,
   output quarkPkg::wordT   rs2
);

   quarkPkg::wordT regs [32];
   quarkPkg::regIdT rs1Id;
   quarkPkg::regIdT rs2Id;

   // Source indices straight from the incoming instruction word
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   always_ff @(posedge clk) begin
      // Operands latched together with the instruction
      // Index 0 reads as zero whatever the array holds
      if (capture) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
      // x0 is never written
      if (writeEn && (rdId != '0)) begin
         regs[rdId] <= writeData;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the quarkCore testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module quarkCoreTb -o quarkCoreSim

./obj_dir/quarkCoreSim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== verification/quarkCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module quarkCoreTb;

   localparam logic [31:0] resetAddr = 32'h0000_0100;
   localparam int addrWidth = 24;
   localparam int progLen = 200;
   // Worst case per instruction is a 31 step shift plus busy waits
   localparam int cycleLimit = progLen * 45;
   localparam logic [31:0] addrMask = 32'h00FF_FFFF;
   localparam logic [31:0] lastAddr = resetAddr + 32'(4 * (progLen - 1));
   // JAL x0 far ahead, only seen by a core that reads while busy
   localparam logic [31:0] staleWord = 32'h0010_006F;

   logic clk;
   logic reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0] memWmask;
   logic [31:0] memRdata;
   logic memRstrb;
   logic memRbusy;
   logic memWbusy;

   // Program image and instruction level model
   logic [31:0] prog [progLen];
   logic [31:0] modelRegs [32];
   logic [31:0] modelPc;
   logic [31:0] expAddrQ [$];
   logic [31:0] expDataQ [$];

   int errors;
   int cycles;
   int fetches;
   int stores;
   int rBusyLeft;
   int wBusyLeft;
   int seedResult;
   logic [31:0] readAddr;
   logic readPending;
   logic storePending;
   logic firstFetch;
   logic done;
   logic timedOut;

   quarkCore #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) i_quarkCore (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRdata (memRdata),
      .memRstrb (memRstrb),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // RV32I encoders
   function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
   endfunction

   function automatic logic [4:0] randReg();
      return 5'($urandom());
   endfunction

   // Shift amounts lean on the edge cases 0 and 31
   function automatic logic [4:0] randShamt();
      int pick;
      pick = int'($urandom() % 4);
      if (pick == 0) begin
         return 5'd0;
      end else if (pick == 1) begin
         return 5'd31;
      end
      return 5'($urandom());
   endfunction

   // Forward step count, never past the final jump
   function automatic int forwardSteps(int idx);
      int room;
      room = progLen - 1 - idx;
      if (room > 6) begin
         room = 6;
      end
      return 1 + int'($urandom() % room);
   endfunction

   task automatic buildProgram();
      int i;
      int r;
      int k;
      logic [2:0] f3;
      logic [4:0] t;
      logic [11:0] imm;
      logic [31:0] target;
      logic landing [progLen];
      // Slots that some earlier jump or branch can land on
      for (i = 0; i < progLen; i++) begin
         landing[i] = 1'b0;
      end
      // x1 to x31 get known values first
      for (i = 1; i < 32; i++) begin
         if (i < 16) begin
            prog[i-1] = encU(20'($urandom()), 5'(i), 7'h37);
         end else begin
            prog[i-1] = encI(12'($urandom()), 5'd0, 3'b000, 5'(i), 7'h13);
         end
      end
      i = 31;
      while (i < progLen - 1) begin
         r = int'($urandom() % 100);
         f3 = 3'($urandom());
         if (r < 22) begin
            // Word store, half of them into the data region off x0
            if ($urandom() % 2 == 0) begin
               imm = 12'h400 + 12'(4 * ($urandom() % 256));
               prog[i] = encS(imm, randReg(), 5'd0);
            end else begin
               prog[i] = encS(12'($urandom()), randReg(), randReg());
            end
            i++;
         end else if (r < 45) begin
            if (f3 == 3'b001) begin
               imm = {7'b0, randShamt()};
            end else if (f3 == 3'b101) begin
               imm = {1'b0, 1'($urandom()), 5'b0, randShamt()};
            end else begin
               imm = 12'($urandom());
            end
            prog[i] = encI(imm, randReg(), f3, randReg(), 7'h13);
            i++;
         end else if (r < 65) begin
            prog[i] = encR(((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, 1'($urandom()), 5'b0} : 7'b0,
                           randReg(), randReg(), f3, randReg());
            i++;
         end else if (r < 72) begin
            prog[i] = encU(20'($urandom()), randReg(), 7'h37);
            i++;
         end else if (r < 77) begin
            prog[i] = encU(20'($urandom()), randReg(), 7'h17);
            i++;
         end else if (r < 88) begin
            // 010 and 011 are not branches
            if ((f3 == 3'b010) || (f3 == 3'b011)) begin
               f3 = f3 + 3'd2;
            end
            k = forwardSteps(i);
            landing[i + k] = 1'b1;
            prog[i] = encB(13'(4 * k), randReg(), randReg(), f3);
            i++;
         end else if (r < 93) begin
            k = forwardSteps(i);
            landing[i + k] = 1'b1;
            prog[i] = encJ(21'(4 * k), randReg());
            i++;
         end else if ((i <= progLen - 4) && !landing[i+1] && !landing[i+2]) begin
            // LUI and ADDI build the JALR target
            // Entry only at the LUI so the target is always complete
            t = 5'(1 + ($urandom() % 31));
            k = forwardSteps(i + 2);
            landing[i + 2 + k] = 1'b1;
            target = resetAddr + 32'(4 * (i + 2 + k));
            prog[i] = encU(20'd0, t, 7'h37);
            prog[i+1] = encI(target[11:0], t, 3'b000, t, 7'h13);
            prog[i+2] = encI(12'd0, t, 3'b000, randReg(), 7'h67);
            i += 3;
         end else begin
            prog[i] = encI(12'($urandom()), randReg(), 3'b000, randReg(), 7'h13);
            i++;
         end
      end
      // Parks the core
      prog[progLen-1] = encJ(21'd0, 5'd0);
   endtask

   function automatic logic [31:0] fetchWord(logic [31:0] addr);
      if ((addr >= resetAddr) && (addr <= lastAddr) && (addr[1:0] == 2'b00)) begin
         return prog[int'((addr - resetAddr) >> 2)];
      end
      // NOP outside the program
      return 32'h0000_0013;
   endfunction

   function automatic logic [31:0] aluOp(logic [2:0] f3, logic alt, logic isReg,
                                         logic [31:0] a, logic [31:0] b);
      case (f3)
         3'b000:  return (alt && isReg) ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011:  return (a < b) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   // One instruction of the reference model
   task automatic stepModel();
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] iImm;
      logic [31:0] sImm;
      logic [31:0] bImm;
      logic [31:0] jImm;
      logic [31:0] nextPc;
      logic [2:0] f3;
      logic wr;
      logic taken;
      ins = fetchWord(modelPc);
      f3 = ins[14:12];
      a = modelRegs[ins[19:15]];
      b = modelRegs[ins[24:20]];
      iImm = {{20{ins[31]}}, ins[31:20]};
      sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      jImm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = (modelPc + 32'd4) & addrMask;
      wr = 1'b1;
      res = '0;
      case (ins[6:0])
         7'h37: res = {ins[31:12], 12'b0};
         // PC relative results are as wide as the address
         7'h17: res = (modelPc + {ins[31:12], 12'b0}) & addrMask;
         7'h6F: begin
            res = (modelPc + 32'd4) & addrMask;
            nextPc = (modelPc + jImm) & addrMask;
         end
         7'h67: begin
            res = (modelPc + 32'd4) & addrMask;
            nextPc = (a + iImm) & addrMask & ~32'd1;
         end
         7'h63: begin
            wr = 1'b0;
            case (f3)
               3'b000:  taken = (a == b);
               3'b001:  taken = (a != b);
               3'b100:  taken = ($signed(a) < $signed(b));
               3'b101:  taken = ($signed(a) >= $signed(b));
               3'b110:  taken = (a < b);
               default: taken = (a >= b);
            endcase
            if (taken) begin
               nextPc = (modelPc + bImm) & addrMask;
            end
         end
         7'h23: begin
            wr = 1'b0;
            expAddrQ.push_back((a + sImm) & addrMask);
            expDataQ.push_back(b);
         end
         7'h13: res = aluOp(f3, ins[30], 1'b0, a, iImm);
         7'h33: res = aluOp(f3, ins[30], 1'b1, a, b);
         default: wr = 1'b0;
      endcase
      if (wr && (ins[11:7] != 5'd0)) begin
         modelRegs[ins[11:7]] = res;
      end
      modelPc = nextPc;
   endtask

   // Memory side, inputs change on the rising edge only
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         timedOut <= 1'b1;
      end
      if (memRstrb) begin
         readAddr = memAddr;
         readPending = 1'b1;
      end
      if ((rBusyLeft == 0) && ($urandom() % 4 == 0)) begin
         rBusyLeft = int'($urandom() % 4);
      end
      memRbusy <= (rBusyLeft > 0);
      // Read data is valid only once busy drops
      if (readPending) begin
         if (rBusyLeft > 0) begin
            memRdata <= staleWord;
         end else begin
            memRdata <= fetchWord(readAddr);
            readPending = 1'b0;
         end
      end
      if (rBusyLeft > 0) begin
         rBusyLeft--;
      end
      if ((wBusyLeft == 0) && ($urandom() % 4 == 0)) begin
         wBusyLeft = int'($urandom() % 4);
      end
      memWbusy <= (wBusyLeft > 0);
      if (wBusyLeft > 0) begin
         wBusyLeft--;
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if ((memWmask != 4'h0) || memRstrb) begin
            errors++;
            $display("Memory strobe active during reset at %0t", $time);
         end
      end else if (!done) begin
         if (memRstrb) begin
            if (storePending) begin
               errors++;
               $display("Fetch at %0t issued before the store was accepted", $time);
            end
            if (firstFetch && (memAddr != resetAddr)) begin
               errors++;
               $display("[FAIL] %0t memAddr first fetch got %h expected %h",
                        $time, memAddr, resetAddr);
            end
            firstFetch = 1'b0;
            if (memAddr != modelPc) begin
               errors++;
               $display("[FAIL] %0t memAddr fetch got %h expected %h", $time, memAddr, modelPc);
            end
            fetches++;
            if (modelPc == lastAddr) begin
               done = 1'b1;
            end
            stepModel();
         end
         if (memWmask != 4'h0) begin
            if (memWmask != 4'hF) begin
               errors++;
               $display("[FAIL] %0t memWmask got %h expected %h", $time, memWmask, 4'hF);
            end
            if (expAddrQ.size() == 0) begin
               errors++;
               $display("Unexpected store at %0t to %h", $time, memAddr);
            end else begin
               if (memAddr != expAddrQ[0]) begin
                  errors++;
                  $display("[FAIL] %0t memAddr store got %h expected %h",
                           $time, memAddr, expAddrQ[0]);
               end
               if (memWdata != expDataQ[0]) begin
                  errors++;
                  $display("[FAIL] %0t memWdata got %h expected %h",
                           $time, memWdata, expDataQ[0]);
               end
               void'(expAddrQ.pop_front());
               void'(expDataQ.pop_front());
               stores++;
            end
            storePending = 1'b1;
         end else if (storePending && !memWbusy && !memRbusy) begin
            storePending = 1'b0;
         end
      end
   end

   initial begin
      seedResult = $urandom(41708);
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      errors = 0;
      cycles = 0;
      fetches = 0;
      stores = 0;
      rBusyLeft = 0;
      wBusyLeft = 0;
      readAddr = '0;
      readPending = 1'b0;
      storePending = 1'b0;
      firstFetch = 1'b1;
      done = 1'b0;
      timedOut = 1'b0;
      for (int r = 0; r < 32; r++) begin
         modelRegs[r] = '0;
      end
      modelPc = resetAddr;
      buildProgram();
      repeat (8) @(posedge clk);
      reset <= 1'b1;
      wait (done || timedOut);
      repeat (2) @(posedge clk);
      if (!done) begin
         errors++;
         $display("Timeout after %0d cycles, the final jump was never fetched", cycles);
      end
      if (expAddrQ.size() != 0) begin
         errors++;
         $display("%0d expected stores never appeared", expAddrQ.size());
      end
      $display("Fetches %0d, stores %0d, errors %0d", fetches, stores, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/quarkCore_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// Memory port protocol of the core
module quarkCoreChk (
   input wire       clk,
   input wire       reset,
   input wire       memRstrb,
   input wire [3:0] memWmask
);

   // Fetch and store never share a cycle
   strbExclusive: assert property (
      @(posedge clk) disable iff (!reset)
      !(memRstrb && (memWmask != 4'h0))
   ) else $error("memRstrb and memWmask active together");

   // A store mask is up for a single cycle
   maskOneCycle: assert property (
      @(posedge clk) disable iff (!reset)
      (memWmask != 4'h0) |=> (memWmask == 4'h0)
   ) else $error("memWmask held longer than one cycle");

   // Reset edge leaves both strobes low
   quietInReset: assert property (
      @(posedge clk)
      !reset |=> ((memWmask == 4'h0) && !memRstrb)
   ) else $error("Memory strobe active during reset");

endmodule

bind quarkCore quarkCoreChk i_quarkCoreChk (
   .clk      (clk),
   .reset    (reset),
   .memRstrb (memRstrb),
   .memWmask (memWmask)
);

`default_nettype wire
